/* spmm_pkg.sv */
`default_nettype none

package spmm_pkg;

  // matrix sizes
  localparam int num_rows  = 8;
  localparam int num_cols  = 8;
  localparam int num_out   = 4;
  localparam int nnz_depth = 32;
  localparam int max_nodes = 15;

  localparam int data_w     = 8;
  localparam int acc_w      = 16;
  localparam int col_w      = $clog2(num_cols);
  localparam int row_w      = $clog2(num_rows);
  localparam int len_w      = $clog2(num_cols + 1);
  localparam int nnz_addr_w = $clog2(nnz_depth);
  localparam int node_w     = $clog2(max_nodes + 1);

  // load port and pending-row FIFO
  localparam int load_w     = 32;
  localparam int fifo_depth = 4;
  localparam int fifo_ptr_w = $clog2(fifo_depth);

  typedef struct packed {
    logic [len_w-1:0]  row_len;
    logic [node_w-1:0] num_nodes;
    logic              src_flag;
  } node_info_t;

  typedef struct packed {
    logic [col_w-1:0]  col_idx;
    logic [data_w-1:0] value;
  } nz_t;

  // lane 0 sits in the top bits
  typedef struct packed {
    logic [0:num_out-1][acc_w-1:0] sum;
    logic [node_w-1:0]             num_nodes;
    logic                          src_flag;
  } wh_t;

  typedef enum logic [1:0] {
    sel_nz        = 2'd0,
    sel_node_info = 2'd1,
    sel_weight    = 2'd2
  } load_sel_t;

endpackage

`default_nettype wire

/* csr_store.sv */
`timescale 1ns/1ps
`default_nettype none

module csr_store (
  input  wire logic                               clk,
  input  wire logic                               load_en_i,
  input  wire spmm_pkg::load_sel_t                load_sel_i,
  input  wire logic [spmm_pkg::nnz_addr_w-1:0]    load_addr_i,
  input  wire logic [spmm_pkg::load_w-1:0]        load_data_i,
  input  wire logic [spmm_pkg::nnz_addr_w-1:0]    nz_addr_i,
  input  wire logic [spmm_pkg::row_w-1:0]         row_addr_i,
  output spmm_pkg::nz_t                           nz_o,
  output spmm_pkg::node_info_t                    node_info_o,
  output spmm_pkg::node_info_t                    node_info_nxt_o
);

  spmm_pkg::nz_t        nz_mem   [spmm_pkg::nnz_depth];
  spmm_pkg::node_info_t node_mem [spmm_pkg::num_rows];

  logic last_row;

  assign last_row = (row_addr_i == spmm_pkg::row_w'(spmm_pkg::num_rows - 1));

  // load port writes
  always_ff @(posedge clk) begin
    if (load_en_i && load_sel_i == spmm_pkg::sel_nz) begin
      nz_mem[load_addr_i] <= load_data_i[$bits(spmm_pkg::nz_t)-1:0];
    end
    if (load_en_i && load_sel_i == spmm_pkg::sel_node_info) begin
      node_mem[load_addr_i[spmm_pkg::row_w-1:0]] <=
        load_data_i[$bits(spmm_pkg::node_info_t)-1:0];
    end
  end

  always_ff @(posedge clk) begin
    nz_o        <= nz_mem[nz_addr_i];
    node_info_o <= node_mem[row_addr_i];
    // nothing follows the last row
    if (last_row) begin
      node_info_nxt_o <= '0;
    end else begin
      node_info_nxt_o <= node_mem[row_addr_i + 1'b1];
    end
  end

endmodule

`default_nettype wire

/* weight_store.sv */
`timescale 1ns/1ps
`default_nettype none

module weight_store (
  input  wire logic                                clk,
  input  wire logic                                load_en_i,
  input  wire spmm_pkg::load_sel_t                 load_sel_i,
  input  wire logic [spmm_pkg::nnz_addr_w-1:0]     load_addr_i,
  input  wire logic [spmm_pkg::load_w-1:0]         load_data_i,
  input  wire logic [spmm_pkg::col_w-1:0]          rd_addr_i,
  output logic [spmm_pkg::num_out-1:0][spmm_pkg::data_w-1:0] weight_row_o
);

  // one row of W per word, lane i in bits [8i+7:8i]
  logic [spmm_pkg::num_out-1:0][spmm_pkg::data_w-1:0] mem [spmm_pkg::num_cols];

  always_ff @(posedge clk) begin
    if (load_en_i && load_sel_i == spmm_pkg::sel_weight) begin
      mem[load_addr_i[spmm_pkg::col_w-1:0]] <= load_data_i;
    end
  end

  always_ff @(posedge clk) begin
    weight_row_o <= mem[rd_addr_i];
  end

endmodule

`default_nettype wire

/* node_info_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

module node_info_fifo (
  input  wire logic                  clk,
  input  wire logic                  rst_n,
  input  wire logic                  push_i,
  input  wire logic                  pop_i,
  input  wire spmm_pkg::node_info_t  data_i,
  output spmm_pkg::node_info_t       data_o,
  output logic                       empty_o,
  output logic                       full_o
);

  spmm_pkg::node_info_t mem [spmm_pkg::fifo_depth];

  logic [spmm_pkg::fifo_ptr_w-1:0] wr_ptr;
  logic [spmm_pkg::fifo_ptr_w-1:0] rd_ptr;
  logic [spmm_pkg::fifo_ptr_w:0]   count;

  assign empty_o = (count == '0);
  assign full_o  = (count == (spmm_pkg::fifo_ptr_w + 1)'(spmm_pkg::fifo_depth));

  // oldest entry always visible
  assign data_o = mem[rd_ptr];

  // a pop frees the oldest slot in the same cycle
  always_ff @(posedge clk) begin
    if (push_i && (!full_o || pop_i)) begin
      mem[wr_ptr] <= data_i;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push_i) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop_i) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      if (push_i && !pop_i) begin
        count <= count + 1'b1;
      end else if (pop_i && !push_i) begin
        count <= count - 1'b1;
      end
    end
  end

  assert property (@(posedge clk) disable iff (!rst_n) !(push_i && full_o && !pop_i));
  assert property (@(posedge clk) disable iff (!rst_n) !(pop_i && empty_o));

endmodule

`default_nettype wire

/* sp_pe.sv */
`timescale 1ns/1ps
`default_nettype none

module sp_pe (
  input  wire logic                          clk,
  input  wire logic                          rst_n,
  input  wire logic                          mac_valid_i,
  input  wire logic                          mac_last_i,
  input  wire logic [spmm_pkg::data_w-1:0]   value_i,
  input  wire logic [spmm_pkg::data_w-1:0]   weight_i,
  output logic      [spmm_pkg::acc_w-1:0]    sum_o,
  output logic                               result_valid_o
);

  logic [spmm_pkg::acc_w-1:0] acc;
  logic [spmm_pkg::acc_w-1:0] acc_nxt;

  // wraps modulo 2^acc_w
  assign acc_nxt = acc + (spmm_pkg::acc_w'(value_i) * spmm_pkg::acc_w'(weight_i));

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      acc            <= '0;
      result_valid_o <= 1'b0;
    end else begin
      result_valid_o <= mac_valid_i && mac_last_i;
      if (mac_valid_i) begin
        // next row may follow right away, so start it from zero
        if (mac_last_i) begin
          acc <= '0;
        end else begin
          acc <= acc_nxt;
        end
      end
    end
  end

  // final row total
  always_ff @(posedge clk) begin
    if (mac_valid_i && mac_last_i) begin
      sum_o <= acc_nxt;
    end
  end

  assert property (@(posedge clk) disable iff (!rst_n)
    $rose(result_valid_o) |-> $past(mac_valid_i));

endmodule

`default_nettype wire

/* spmm_core.sv */
`timescale 1ns/1ps
`default_nettype none

module spmm_core (
  input  wire logic                                clk,
  input  wire logic                                rst_n,
  input  wire logic                                start_i,
  output logic                                     busy_o,
  output logic                                     done_o,
  output logic [spmm_pkg::nnz_addr_w-1:0]          nz_addr_o,
  output logic [spmm_pkg::row_w-1:0]               row_addr_o,
  input  wire spmm_pkg::nz_t                       nz_i,
  input  wire spmm_pkg::node_info_t                node_info_i,
  input  wire spmm_pkg::node_info_t                node_info_nxt_i,
  output logic [spmm_pkg::col_w-1:0]               weight_addr_o,
  input  wire logic [spmm_pkg::num_out-1:0][spmm_pkg::data_w-1:0] weight_row_i,
  output logic                                     wh_valid_o,
  output spmm_pkg::wh_t                            wh_o,
  output logic [spmm_pkg::row_w-1:0]               wh_addr_o
);

  logic                             issuing;
  logic [spmm_pkg::nnz_addr_w-1:0]  nz_addr;
  logic [spmm_pkg::row_w-1:0]       row_idx;
  logic [spmm_pkg::row_w-1:0]       wh_addr;
  logic [spmm_pkg::len_w-1:0]       left;
  logic [spmm_pkg::len_w-1:0]       left_nxt;
  logic                             row_start;
  logic                             is_last;
  spmm_pkg::node_info_t             start_info;

  logic                             v1;
  logic                             v2;
  logic                             last1;
  logic                             last2;
  logic [spmm_pkg::data_w-1:0]      value2;

  logic [spmm_pkg::num_out-1:0]     res_valid;
  logic [spmm_pkg::acc_w-1:0]       sums [spmm_pkg::num_out];
  spmm_pkg::node_info_t             fifo_out;
  logic                             fifo_empty;

  assign nz_addr_o     = nz_addr;
  assign row_addr_o    = row_idx;
  assign wh_addr_o     = wh_addr;
  assign weight_addr_o = nz_i.col_idx;
  assign row_start     = issuing && (left == '0);
  // every lane closes its row in the same cycle
  assign wh_valid_o    = &res_valid;

  // first row from the current-row port and later rows from the look-ahead port
  assign start_info = (nz_addr == '0) ? node_info_i : node_info_nxt_i;

  always_comb begin
    if (left == '0) begin
      is_last  = (start_info.row_len == spmm_pkg::len_w'(1));
      left_nxt = start_info.row_len - 1'b1;
    end else begin
      is_last  = (left == spmm_pkg::len_w'(1));
      left_nxt = left - 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      busy_o  <= 1'b0;
      done_o  <= 1'b0;
      issuing <= 1'b0;
      nz_addr <= '0;
      row_idx <= '0;
      left    <= '0;
      wh_addr <= '0;
      v1      <= 1'b0;
      v2      <= 1'b0;
    end else begin
      done_o <= 1'b0;
      v1     <= issuing;
      v2     <= v1;
      if (start_i && !busy_o) begin
        busy_o  <= 1'b1;
        issuing <= 1'b1;
        nz_addr <= '0;
        left    <= '0;
        wh_addr <= '0;
      end else begin
        if (issuing) begin
          nz_addr <= nz_addr + 1'b1;
          left    <= left_nxt;
          if (is_last) begin
            if (row_idx == spmm_pkg::row_w'(spmm_pkg::num_rows - 1)) begin
              issuing <= 1'b0;
              row_idx <= '0;
            end else begin
              row_idx <= row_idx + 1'b1;
            end
          end
        end
        if (wh_valid_o) begin
          wh_addr <= wh_addr + 1'b1;
          if (wh_addr == spmm_pkg::row_w'(spmm_pkg::num_rows - 1)) begin
            busy_o <= 1'b0;
            done_o <= 1'b1;
          end
        end
      end
    end
  end

  // line up with the weight read
  always_ff @(posedge clk) begin
    last1  <= is_last;
    last2  <= last1;
    value2 <= nz_i.value;
  end

  for (genvar i = 0; i < spmm_pkg::num_out; i++) begin : g_pe
    sp_pe u_pe (
      .clk            (clk),
      .rst_n          (rst_n),
      .mac_valid_i    (v2),
      .mac_last_i     (last2),
      .value_i        (value2),
      .weight_i       (weight_row_i[i]),
      .sum_o          (sums[i]),
      .result_valid_o (res_valid[i])
    );
  end

  node_info_fifo u_fifo (
    .clk     (clk),
    .rst_n   (rst_n),
    .push_i  (row_start),
    .pop_i   (wh_valid_o),
    .data_i  (start_info),
    .data_o  (fifo_out),
    .empty_o (fifo_empty),
    .full_o  ()
  );

  always_comb begin
    for (int i = 0; i < spmm_pkg::num_out; i++) begin
      wh_o.sum[i] = sums[i];
    end
    wh_o.num_nodes = fifo_out.num_nodes;
    wh_o.src_flag  = fifo_out.src_flag;
  end

  assert property (@(posedge clk) disable iff (!rst_n) wh_valid_o |-> !fifo_empty);

endmodule

`default_nettype wire

/* spmm_top.sv */
`timescale 1ns/1ps
`default_nettype none

module spmm_top (
  input  wire logic                              clk,
  input  wire logic                              rst_n,
  input  wire logic                              start_i,
  output logic                                   busy_o,
  output logic                                   done_o,
  input  wire logic                              load_en_i,
  input  wire spmm_pkg::load_sel_t               load_sel_i,
  input  wire logic [spmm_pkg::nnz_addr_w-1:0]   load_addr_i,
  input  wire logic [spmm_pkg::load_w-1:0]       load_data_i,
  output logic                                   wh_valid_o,
  output spmm_pkg::wh_t                          wh_o,
  output logic [spmm_pkg::row_w-1:0]             wh_addr_o
);

  logic [spmm_pkg::nnz_addr_w-1:0] nz_addr;
  logic [spmm_pkg::row_w-1:0]      row_addr;
  logic [spmm_pkg::col_w-1:0]      weight_addr;
  spmm_pkg::nz_t                   nz;
  spmm_pkg::node_info_t            node_info;
  spmm_pkg::node_info_t            node_info_nxt;
  logic [spmm_pkg::num_out-1:0][spmm_pkg::data_w-1:0] weight_row;

  csr_store u_csr (
    .clk             (clk),
    .load_en_i       (load_en_i),
    .load_sel_i      (load_sel_i),
    .load_addr_i     (load_addr_i),
    .load_data_i     (load_data_i),
    .nz_addr_i       (nz_addr),
    .row_addr_i      (row_addr),
    .nz_o            (nz),
    .node_info_o     (node_info),
    .node_info_nxt_o (node_info_nxt)
  );

  weight_store u_weight (
    .clk          (clk),
    .load_en_i    (load_en_i),
    .load_sel_i   (load_sel_i),
    .load_addr_i  (load_addr_i),
    .load_data_i  (load_data_i),
    .rd_addr_i    (weight_addr),
    .weight_row_o (weight_row)
  );

  spmm_core u_core (
    .clk             (clk),
    .rst_n           (rst_n),
    .start_i         (start_i),
    .busy_o          (busy_o),
    .done_o          (done_o),
    .nz_addr_o       (nz_addr),
    .row_addr_o      (row_addr),
    .nz_i            (nz),
    .node_info_i     (node_info),
    .node_info_nxt_i (node_info_nxt),
    .weight_addr_o   (weight_addr),
    .weight_row_i    (weight_row),
    .wh_valid_o      (wh_valid_o),
    .wh_o            (wh_o),
    .wh_addr_o       (wh_addr_o)
  );

endmodule

`default_nettype wire

/* tb_clock.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clock (
  output logic clk_o
);

  initial clk_o = 1'b0;

  // 10 ns period
  always #5 clk_o = ~clk_o;

endmodule

`default_nettype wire

/* tb_spmm.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_spmm;

  typedef struct packed {
    logic [0:spmm_pkg::num_rows-1][spmm_pkg::len_w-1:0] lens;
    logic                                                all_ones;
  } case_t;

  logic                            clk;
  logic                            rst_n;
  logic                            start_i;
  logic                            busy_o;
  logic                            done_o;
  logic                            load_en_i;
  spmm_pkg::load_sel_t             load_sel_i;
  logic [spmm_pkg::nnz_addr_w-1:0] load_addr_i;
  logic [spmm_pkg::load_w-1:0]     load_data_i;
  logic                            wh_valid_o;
  spmm_pkg::wh_t                   wh_o;
  logic [spmm_pkg::row_w-1:0]      wh_addr_o;

  case_t                      cases [3];
  string                      names [3];
  spmm_pkg::nz_t              h_nz [spmm_pkg::nnz_depth];
  spmm_pkg::node_info_t       row_info [spmm_pkg::num_rows];
  logic [spmm_pkg::num_out-1:0][spmm_pkg::data_w-1:0] w_row [spmm_pkg::num_cols];
  spmm_pkg::wh_t              got_wh [spmm_pkg::num_rows];
  logic [spmm_pkg::row_w-1:0] got_addr [spmm_pkg::num_rows];

  logic [15:0] lfsr;
  bit          watching;
  int          cyc;
  int          n_busy;
  int          n_done;
  int          done_cyc;
  int          n_wh;
  int          cycle_cnt;
  int          timeout_limit;
  int          checks;
  int          errors;

  tb_clock u_clock (.clk_o(clk));

  spmm_top dut (
    .clk         (clk),
    .rst_n       (rst_n),
    .start_i     (start_i),
    .busy_o      (busy_o),
    .done_o      (done_o),
    .load_en_i   (load_en_i),
    .load_sel_i  (load_sel_i),
    .load_addr_i (load_addr_i),
    .load_data_i (load_data_i),
    .wh_valid_o  (wh_valid_o),
    .wh_o        (wh_o),
    .wh_addr_o   (wh_addr_o)
  );

  // galois form with taps 16 14 13 11
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    if (s[0]) begin
      return (s >> 1) ^ 16'hB400;
    end
    return s >> 1;
  endfunction

  function automatic logic [7:0] take_bits(input int n);
    logic [7:0] r;
    r = '0;
    for (int b = 0; b < n; b++) begin
      r    = {r[6:0], lfsr[0]};
      lfsr = lfsr_next(lfsr);
    end
    return r;
  endfunction

  function automatic int case_nnz(input case_t tc);
    int sum;
    sum = 0;
    for (int r = 0; r < spmm_pkg::num_rows; r++) begin
      sum += int'(tc.lens[r]);
    end
    return sum;
  endfunction

  task automatic check_value(input string what, input logic [31:0] exp, input logic [31:0] got);
    checks++;
    assert (got == exp) else begin
      errors++;
      $display("ERROR %s: expected %0h, got %0h", what, exp, got);
    end
  endtask

  task automatic build_case(input case_t tc, output int nnz);
    int k;
    k = 0;
    for (int r = 0; r < spmm_pkg::num_rows; r++) begin
      row_info[r].row_len   = tc.lens[r];
      row_info[r].num_nodes = spmm_pkg::node_w'(take_bits(spmm_pkg::node_w));
      row_info[r].src_flag  = (take_bits(1) != 8'd0);
      for (int j = 0; j < int'(tc.lens[r]); j++) begin
        if (tc.all_ones) begin
          h_nz[k].col_idx = spmm_pkg::col_w'(j);
          h_nz[k].value   = 8'hFF;
        end else begin
          h_nz[k].col_idx = spmm_pkg::col_w'(take_bits(spmm_pkg::col_w));
          h_nz[k].value   = take_bits(spmm_pkg::data_w);
        end
        k++;
      end
    end
    for (int r = 0; r < spmm_pkg::num_cols; r++) begin
      for (int i = 0; i < spmm_pkg::num_out; i++) begin
        w_row[r][i] = tc.all_ones ? 8'hFF : take_bits(spmm_pkg::data_w);
      end
    end
    nnz = k;
  endtask

  task automatic load_word(input spmm_pkg::load_sel_t sel, input int addr,
                           input logic [31:0] data);
    @(posedge clk);
    load_en_i   <= 1'b1;
    load_sel_i  <= sel;
    load_addr_i <= spmm_pkg::nnz_addr_w'(addr);
    load_data_i <= data;
  endtask

  task automatic load_all(input int nnz);
    for (int k = 0; k < nnz; k++) begin
      load_word(spmm_pkg::sel_nz, k, 32'(h_nz[k]));
    end
    for (int r = 0; r < spmm_pkg::num_rows; r++) begin
      load_word(spmm_pkg::sel_node_info, r, 32'(row_info[r]));
    end
    for (int r = 0; r < spmm_pkg::num_cols; r++) begin
      load_word(spmm_pkg::sel_weight, r, 32'(w_row[r]));
    end
    @(posedge clk);
    load_en_i <= 1'b0;
  endtask

  // reference model sums value * W[col][lane] per row modulo 2^16
  task automatic check_run(input string name, input int nnz);
    int          k;
    logic [15:0] acc;
    k = 0;
    check_value({name, " result count"}, spmm_pkg::num_rows, n_wh);
    check_value({name, " done count"}, 1, n_done);
    check_value({name, " done cycle"}, nnz + 4, done_cyc);
    check_value({name, " busy cycles"}, nnz + 3, n_busy);
    for (int r = 0; r < spmm_pkg::num_rows; r++) begin
      check_value($sformatf("%s row %0d address", name, r), r, 32'(got_addr[r]));
      for (int i = 0; i < spmm_pkg::num_out; i++) begin
        acc = '0;
        for (int j = 0; j < int'(row_info[r].row_len); j++) begin
          acc = acc + 16'(h_nz[k+j].value) * 16'(w_row[h_nz[k+j].col_idx][i]);
        end
        check_value($sformatf("%s row %0d lane %0d", name, r, i), 32'(acc),
                    32'(got_wh[r].sum[i]));
      end
      check_value($sformatf("%s row %0d nodes", name, r), 32'(row_info[r].num_nodes),
                  32'(got_wh[r].num_nodes));
      check_value($sformatf("%s row %0d source", name, r), 32'(row_info[r].src_flag),
                  32'(got_wh[r].src_flag));
      k += int'(row_info[r].row_len);
    end
  endtask

  task automatic run_once(input string name, input int nnz);
    @(posedge clk);
    start_i <= 1'b1;
    @(posedge clk);
    start_i  <= 1'b0;
    cyc      = 0;
    n_busy   = 0;
    n_done   = 0;
    done_cyc = 0;
    n_wh     = 0;
    watching = 1'b1;
    while (n_done == 0) begin
      @(posedge clk);
    end
    // stray pulses after done would show up here
    repeat (4) @(posedge clk);
    watching = 1'b0;
    check_run(name, nnz);
  endtask

  // cycle 1 is the first cycle after start was taken
  always @(negedge clk) begin
    if (watching) begin
      cyc++;
      if (busy_o) begin
        n_busy++;
      end
      if (done_o) begin
        n_done++;
        done_cyc = cyc;
      end
      if (wh_valid_o) begin
        if (n_wh < spmm_pkg::num_rows) begin
          got_wh[n_wh]   = wh_o;
          got_addr[n_wh] = wh_addr_o;
        end
        n_wh++;
      end
    end
  end

  always @(posedge clk) begin
    cycle_cnt++;
    if (cycle_cnt > timeout_limit) begin
      $display("timeout after %0d cycles, a run never reached done", cycle_cnt);
      $display("Finished with errors");
      $finish;
    end
  end

  initial begin
    int nnz;
    rst_n       = 1'b0;
    start_i     = 1'b0;
    load_en_i   = 1'b0;
    load_sel_i  = spmm_pkg::sel_nz;
    load_addr_i = '0;
    load_data_i = '0;
    lfsr        = 16'd65;
    watching    = 1'b0;
    cycle_cnt   = 0;
    checks      = 0;
    errors      = 0;

    // wrap_255 uses all 32 nonzero slots
    names[0] = "mixed_rows";
    cases[0] = '{lens: {4'd3, 4'd5, 4'd2, 4'd4, 4'd1, 4'd6, 4'd3, 4'd4}, all_ones: 1'b0};
    names[1] = "single_nz";
    cases[1] = '{lens: {8{4'd1}}, all_ones: 1'b0};
    names[2] = "wrap_255";
    cases[2] = '{lens: {4'd8, 4'd1, 4'd8, 4'd1, 4'd8, 4'd1, 4'd2, 4'd3}, all_ones: 1'b1};

    timeout_limit = 16;
    for (int c = 0; c < $size(cases); c++) begin
      timeout_limit += 2 * (case_nnz(cases[c]) + 40 + 20);
    end

    repeat (16) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    check_value("reset busy", 0, 32'(busy_o));
    check_value("reset done", 0, 32'(done_o));
    check_value("reset wh_valid", 0, 32'(wh_valid_o));

    for (int c = 0; c < $size(cases); c++) begin
      build_case(cases[c], nnz);
      load_all(nnz);
      for (int run = 1; run <= 2; run++) begin
        run_once($sformatf("%s run %0d", names[c], run), nnz);
      end
    end

    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* spmm_top.f */
spmm_pkg.sv
csr_store.sv
weight_store.sv
node_info_fifo.sv
sp_pe.sv
spmm_core.sv
spmm_top.sv
tb_clock.sv
tb_spmm.sv

/* Makefile */
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -Wno-fatal
TOP       := tb_spmm
FILELIST  := spmm_top.f
OBJ_DIR   := obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output"
	@echo "  help   list the targets"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "^Finished with no errors$$"

clean:
	rm -rf $(OBJ_DIR)
